// ==== logic/backend_pkg.sv ====
`default_nettype none

package backend_pkg;

  localparam int ILEN     = 32;
  localparam int NUM_REGS = 32;
  localparam int REG_AW   = 5;

  // Major opcodes accepted by the back end
  localparam logic [6:0] OPC_REG = 7'b0110011;
  localparam logic [6:0] OPC_IMM = 7'b0010011;

  typedef struct packed {
    logic [6:0]        funct7;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rs1;
    logic [2:0]        funct3;
    logic [REG_AW-1:0] rd;
    logic [6:0]        opcode;
  } r_form_t;

  typedef struct packed {
    logic [11:0]       imm12;
    logic [REG_AW-1:0] rs1;
    logic [2:0]        funct3;
    logic [REG_AW-1:0] rd;
    logic [6:0]        opcode;
  } i_form_t;

  // One instruction word, viewed as either encoding
  typedef union packed {
    r_form_t r;
    i_form_t i;
  } instr_word_u;

  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_MUL
  } alu_op_e;

  typedef struct packed {
    alu_op_e           op;
    logic [REG_AW-1:0] rd;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic              use_imm;
    logic [11:0]       imm12;
  } decoded_op_t;

  // What the bypass network needs to know about an EX stage
  typedef struct packed {
    logic              pending;
    logic [REG_AW-1:0] rd;
    logic              data_valid;
  } stage_tag_t;

  typedef struct packed {
    logic              valid;
    logic [REG_AW-1:0] rd;
  } retire_t;

endpackage

`default_nettype wire

// ==== logic/instr_intake.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_intake (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            instr_req_i,
  input  logic [backend_pkg::ILEN-1:0]    instr_word_i,
  input  logic                            issue_ready_i,
  output logic                            instr_ack_o,
  output logic                            dec_valid_o,
  output backend_pkg::decoded_op_t        dec_op_o
);

  backend_pkg::instr_word_u word;
  backend_pkg::decoded_op_t dec_next;
  logic                     dec_legal;
  logic                     acked_q;
  logic                     dec_valid_q;
  logic                     capture;

  assign word = instr_word_i;

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////

  always_comb begin
    dec_legal = 1'b0;
    dec_next = '0;
    dec_next.rd = word.r.rd;
    dec_next.rs1 = word.r.rs1;
    unique case (word.r.opcode)
      backend_pkg::OPC_REG: begin
        dec_next.rs2 = word.r.rs2;
        dec_legal = 1'b1;
        unique case ({word.r.funct7, word.r.funct3})
          10'b0000000_000: dec_next.op = backend_pkg::OP_ADD;
          10'b0100000_000: dec_next.op = backend_pkg::OP_SUB;
          10'b0000000_111: dec_next.op = backend_pkg::OP_AND;
          10'b0000000_110: dec_next.op = backend_pkg::OP_OR;
          10'b0000000_100: dec_next.op = backend_pkg::OP_XOR;
          10'b0000001_000: dec_next.op = backend_pkg::OP_MUL;
          default: dec_legal = 1'b0;
        endcase
      end
      backend_pkg::OPC_IMM: begin
        // rs2 stays x0, so only rs1 can ever cause a hazard
        dec_next.use_imm = 1'b1;
        dec_next.imm12 = word.i.imm12;
        dec_legal = 1'b1;
        unique case (word.i.funct3)
          3'b000: dec_next.op = backend_pkg::OP_ADD;
          3'b111: dec_next.op = backend_pkg::OP_AND;
          3'b110: dec_next.op = backend_pkg::OP_OR;
          3'b100: dec_next.op = backend_pkg::OP_XOR;
          default: dec_legal = 1'b0;
        endcase
      end
      default: ;
    endcase
  end

  //////////////////////////////////////////////////
  // Four-phase handshake and decode slot
  //////////////////////////////////////////////////

  // Take a word only when the slot is empty or drains this cycle
  assign capture = !acked_q && instr_req_i && (!dec_valid_q || issue_ready_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acked_q <= 1'b0;
      dec_valid_q <= 1'b0;
    end else begin
      if (capture) begin
        acked_q <= 1'b1;
      end else if (acked_q && !instr_req_i) begin
        acked_q <= 1'b0;
      end

      if (capture) begin
        dec_valid_q <= dec_legal;
      end else if (issue_ready_i) begin
        dec_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) begin
      dec_op_o <= dec_next;
    end
  end

  assign instr_ack_o = acked_q;
  assign dec_valid_o = dec_valid_q;

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file #(
  parameter int XLEN = 32
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic [backend_pkg::REG_AW-1:0] raddr_a_i,
  input  logic [backend_pkg::REG_AW-1:0] raddr_b_i,
  input  logic [backend_pkg::REG_AW-1:0] waddr_i,
  input  logic [XLEN-1:0]                wdata_i,
  input  logic                           we_i,
  output logic [XLEN-1:0]                rdata_a_o,
  output logic [XLEN-1:0]                rdata_b_o
);

  // No storage for x0
  logic [XLEN-1:0] regs_q [1:backend_pkg::NUM_REGS-1];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < backend_pkg::NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

`default_nettype wire

// ==== logic/operand_bypass.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_bypass #(
  parameter int XLEN = 32
) (
  input  backend_pkg::decoded_op_t dec_op_i,
  input  logic [XLEN-1:0]          rf_a_i,
  input  logic [XLEN-1:0]          rf_b_i,
  input  backend_pkg::stage_tag_t  ex1_tag_i,
  input  logic [XLEN-1:0]          ex1_data_i,
  input  backend_pkg::stage_tag_t  ex2_tag_i,
  input  logic [XLEN-1:0]          ex2_data_i,
  output logic [XLEN-1:0]          opnd_a_o,
  output logic [XLEN-1:0]          opnd_b_o,
  output logic                     data_hazard_o
);

  logic hazard_a;
  logic hazard_b;

  // Resolve one source; result is {hazard, value}
  function automatic logic [XLEN:0] resolve(
    input logic                           used,
    input logic [backend_pkg::REG_AW-1:0] src,
    input logic [XLEN-1:0]                rf_val,
    input backend_pkg::stage_tag_t        t1,
    input logic [XLEN-1:0]                d1,
    input backend_pkg::stage_tag_t        t2,
    input logic [XLEN-1:0]                d2
  );
    logic            haz;
    logic [XLEN-1:0] val;
    haz = 1'b0;
    val = rf_val;
    if (used && src != '0) begin
      // Youngest producer wins
      if (t1.pending && t1.rd == src) begin
        val = d1;
        haz = !t1.data_valid;
      end else if (t2.pending && t2.rd == src) begin
        val = d2;
        haz = !t2.data_valid;
      end
    end
    return {haz, val};
  endfunction

  assign {hazard_a, opnd_a_o} = resolve(1'b1, dec_op_i.rs1, rf_a_i,
                                        ex1_tag_i, ex1_data_i, ex2_tag_i, ex2_data_i);
  assign {hazard_b, opnd_b_o} = resolve(!dec_op_i.use_imm, dec_op_i.rs2, rf_b_i,
                                        ex1_tag_i, ex1_data_i, ex2_tag_i, ex2_data_i);

  assign data_hazard_o = hazard_a || hazard_b;

endmodule

`default_nettype wire

// ==== logic/seq_multiplier.sv ====
`timescale 1ns/1ps
`default_nettype none

module seq_multiplier #(
  parameter int XLEN = 32
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            req_valid_i,
  input  logic [XLEN-1:0] operand_a_i,
  input  logic [XLEN-1:0] operand_b_i,
  input  logic            resp_ready_i,
  output logic            req_ready_o,
  output logic            resp_valid_o,
  output logic [XLEN-1:0] resp_value_o
);

  localparam int CNT_W = $clog2(XLEN);

  logic             busy_q;
  logic             done_q;
  logic [CNT_W-1:0] cnt_q;
  logic [XLEN-1:0]  acc_q;
  logic [XLEN-1:0]  mcand_q;
  logic [XLEN-1:0]  mplier_q;
  logic             accept;

  assign req_ready_o = !busy_q && !done_q;
  assign accept = req_valid_i && req_ready_o;

  // Control: idle -> busy for XLEN steps -> done until taken
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q <= '0;
    end else if (accept) begin
      busy_q <= 1'b1;
      cnt_q <= '0;
    end else if (busy_q) begin
      cnt_q <= cnt_q + 1'b1;
      if (cnt_q == CNT_W'(XLEN - 1)) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
    end else if (done_q && resp_ready_i) begin
      done_q <= 1'b0;
    end
  end

  // Datapath, one multiplier bit per step
  always_ff @(posedge clk_i) begin
    if (accept) begin
      acc_q <= '0;
      mcand_q <= operand_a_i;
      mplier_q <= operand_b_i;
    end else if (busy_q) begin
      if (mplier_q[0]) begin
        acc_q <= acc_q + mcand_q;
      end
      mcand_q <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  assign resp_valid_o = done_q;
  assign resp_value_o = acc_q;

endmodule

`default_nettype wire

// ==== logic/exec_pipeline.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_pipeline #(
  parameter int XLEN = 32
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           dec_valid_i,
  input  backend_pkg::decoded_op_t       dec_op_i,
  input  logic [XLEN-1:0]                rf_a_i,
  input  logic [XLEN-1:0]                rf_b_i,
  output logic                           issue_ready_o,
  output logic                           rf_we_o,
  output logic [backend_pkg::REG_AW-1:0] rf_waddr_o,
  output logic [XLEN-1:0]                rf_wdata_o,
  output backend_pkg::retire_t           retire_o,
  output logic [XLEN-1:0]                retire_data_o
);

  logic [XLEN-1:0] opnd_a, opnd_b, imm_sext, alu_b, alu_result;
  logic            data_hazard, struct_hazard, issue, is_mul;
  logic            mul_ready, mul_valid, mul_owned;
  logic [XLEN-1:0] mul_data;
  backend_pkg::stage_tag_t ex1_tag, ex2_tag;

  // Stage state; *_mul marks a result still owed by the multiplier
  logic                           ex1_pending_q, ex1_pending_d, ex1_mul_q, ex1_mul_d;
  logic [backend_pkg::REG_AW-1:0] ex1_rd_q, ex1_rd_d;
  logic [XLEN-1:0]                ex1_alu_q, ex1_alu_d, ex1_data;
  logic                           ex1_data_valid, ex1_ready;
  logic                           ex2_pending_q, ex2_pending_d, ex2_mul_q, ex2_mul_d;
  logic [backend_pkg::REG_AW-1:0] ex2_rd_q, ex2_rd_d;
  logic [XLEN-1:0]                ex2_alu_q, ex2_alu_d, ex2_data;
  logic                           ex2_data_valid, ex2_ready, retire;

  assign ex1_tag = '{pending: ex1_pending_q, rd: ex1_rd_q, data_valid: ex1_data_valid};
  assign ex2_tag = '{pending: ex2_pending_q, rd: ex2_rd_q, data_valid: ex2_data_valid};

  operand_bypass #(
    .XLEN (XLEN)
  ) u_bypass (
    .dec_op_i      (dec_op_i),
    .rf_a_i        (rf_a_i),
    .rf_b_i        (rf_b_i),
    .ex1_tag_i     (ex1_tag),
    .ex1_data_i    (ex1_data),
    .ex2_tag_i     (ex2_tag),
    .ex2_data_i    (ex2_data),
    .opnd_a_o      (opnd_a),
    .opnd_b_o      (opnd_b),
    .data_hazard_o (data_hazard)
  );

  //////////////////////////////////////////////////
  // Issue and ALU
  //////////////////////////////////////////////////

  assign is_mul = dec_op_i.op == backend_pkg::OP_MUL;
  assign struct_hazard = !ex1_ready || (is_mul && !mul_ready);
  assign issue_ready_o = !data_hazard && !struct_hazard;
  assign issue = dec_valid_i && issue_ready_o;

  assign imm_sext = {{(XLEN - 12){dec_op_i.imm12[11]}}, dec_op_i.imm12};
  assign alu_b = dec_op_i.use_imm ? imm_sext : opnd_b;

  always_comb begin
    unique case (dec_op_i.op)
      backend_pkg::OP_SUB: alu_result = opnd_a - alu_b;
      backend_pkg::OP_AND: alu_result = opnd_a & alu_b;
      backend_pkg::OP_OR:  alu_result = opnd_a | alu_b;
      backend_pkg::OP_XOR: alu_result = opnd_a ^ alu_b;
      default:             alu_result = opnd_a + alu_b;
    endcase
  end

  // Whichever stage owns the MUL consumes the response in the cycle it shows up
  assign mul_owned = (ex1_pending_q && ex1_mul_q) || (ex2_pending_q && ex2_mul_q);

  seq_multiplier #(
    .XLEN (XLEN)
  ) u_mul (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (issue && is_mul),
    .operand_a_i  (opnd_a),
    .operand_b_i  (opnd_b),
    .resp_ready_i (mul_owned),
    .req_ready_o  (mul_ready),
    .resp_valid_o (mul_valid),
    .resp_value_o (mul_data)
  );

  //////////////////////////////////////////////////
  // EX1 and EX2 stages
  //////////////////////////////////////////////////

  assign ex1_data_valid = ex1_mul_q ? (mul_valid && !ex2_mul_q) : 1'b1;
  assign ex1_data = ex1_mul_q ? mul_data : ex1_alu_q;
  assign ex2_data_valid = ex2_mul_q ? mul_valid : 1'b1;
  assign ex2_data = ex2_mul_q ? mul_data : ex2_alu_q;

  assign ex2_ready = !ex2_pending_q || ex2_data_valid;
  assign ex1_ready = ex2_ready || !ex1_pending_q;
  assign retire = ex2_pending_q && ex2_data_valid;

  always_comb begin
    ex1_pending_d = ex1_pending_q;
    ex1_mul_d = ex1_mul_q;
    ex1_rd_d = ex1_rd_q;
    ex1_alu_d = ex1_alu_q;
    // A result that arrived early is folded into the ALU data register
    if (ex1_data_valid) begin
      ex1_mul_d = 1'b0;
      ex1_alu_d = ex1_data;
    end
    if (ex2_ready) begin
      ex1_pending_d = 1'b0;
      ex1_mul_d = 1'b0;
    end
    if (issue) begin
      ex1_pending_d = 1'b1;
      ex1_mul_d = is_mul;
      ex1_rd_d = dec_op_i.rd;
      ex1_alu_d = alu_result;
    end

    ex2_pending_d = ex2_pending_q;
    ex2_mul_d = ex2_mul_q;
    ex2_rd_d = ex2_rd_q;
    ex2_alu_d = ex2_alu_q;
    if (ex2_data_valid) begin
      ex2_pending_d = 1'b0;
      ex2_mul_d = 1'b0;
    end
    if (ex1_pending_q && ex2_ready) begin
      ex2_pending_d = 1'b1;
      ex2_mul_d = ex1_mul_q && !ex1_data_valid;
      ex2_rd_d = ex1_rd_q;
      ex2_alu_d = ex1_data;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ex1_pending_q <= 1'b0;
      ex1_mul_q <= 1'b0;
      ex2_pending_q <= 1'b0;
      ex2_mul_q <= 1'b0;
    end else begin
      ex1_pending_q <= ex1_pending_d;
      ex1_mul_q <= ex1_mul_d;
      ex2_pending_q <= ex2_pending_d;
      ex2_mul_q <= ex2_mul_d;
    end
  end

  always_ff @(posedge clk_i) begin
    ex1_rd_q <= ex1_rd_d;
    ex1_alu_q <= ex1_alu_d;
    ex2_rd_q <= ex2_rd_d;
    ex2_alu_q <= ex2_alu_d;
  end

  // Retire and write back from EX2
  assign rf_we_o = retire;
  assign rf_waddr_o = ex2_rd_q;
  assign rf_wdata_o = ex2_data;
  assign retire_o = '{valid: retire, rd: ex2_rd_q};
  assign retire_data_o = (ex2_rd_q == '0) ? '0 : ex2_data;

endmodule

`default_nettype wire

// ==== logic/backend_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module backend_top #(
  parameter int XLEN = 32
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         instr_req_i,
  input  logic [backend_pkg::ILEN-1:0] instr_word_i,
  output logic                         instr_ack_o,
  output backend_pkg::retire_t         retire_o,
  output logic [XLEN-1:0]              retire_data_o
);

  logic                           dec_valid;
  backend_pkg::decoded_op_t       dec_op;
  logic                           issue_ready;
  logic [XLEN-1:0]                rf_a, rf_b, rf_wdata;
  logic                           rf_we;
  logic [backend_pkg::REG_AW-1:0] rf_waddr;

  instr_intake u_intake (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .instr_req_i   (instr_req_i),
    .instr_word_i  (instr_word_i),
    .issue_ready_i (issue_ready),
    .instr_ack_o   (instr_ack_o),
    .dec_valid_o   (dec_valid),
    .dec_op_o      (dec_op)
  );

  // Read ports follow the decode slot
  reg_file #(
    .XLEN (XLEN)
  ) u_reg_file (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (dec_op.rs1),
    .raddr_b_i (dec_op.rs2),
    .waddr_i   (rf_waddr),
    .wdata_i   (rf_wdata),
    .we_i      (rf_we),
    .rdata_a_o (rf_a),
    .rdata_b_o (rf_b)
  );

  exec_pipeline #(
    .XLEN (XLEN)
  ) u_pipe (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .dec_valid_i   (dec_valid),
    .dec_op_i      (dec_op),
    .rf_a_i        (rf_a),
    .rf_b_i        (rf_b),
    .issue_ready_o (issue_ready),
    .rf_we_o       (rf_we),
    .rf_waddr_o    (rf_waddr),
    .rf_wdata_o    (rf_wdata),
    .retire_o      (retire_o),
    .retire_data_o (retire_data_o)
  );

endmodule

`default_nettype wire

// ==== test/backend_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module backend_chk (
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic                 instr_req_i,
  input logic                 instr_ack_i,
  input backend_pkg::retire_t retire_i
);

  // Count of failed assertions
  int fail_count = 0;

  // Ack only answers a request seen on the previous clock
  ack_rise_on_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(instr_ack_i) |-> $past(instr_req_i))
    else begin
      $error("instr_ack rose with no request pending");
      fail_count++;
    end

  // While req is still high the ack must hold
  ack_held_with_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_ack_i && instr_req_i |=> instr_ack_i)
    else begin
      $error("instr_ack dropped while instr_req was still high");
      fail_count++;
    end

  no_retire_in_reset: assert property (@(posedge clk_i)
    !rst_ni |-> !retire_i.valid)
    else begin
      $error("retire valid high during reset");
      fail_count++;
    end

endmodule

bind backend_top backend_chk u_chk (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .instr_req_i (instr_req_i),
  .instr_ack_i (instr_ack_o),
  .retire_i    (retire_o)
);

`default_nettype wire

// ==== test/tb_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_checker #(
  parameter int XLEN = 32
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         instr_ack_i,
  input  logic [backend_pkg::ILEN-1:0] instr_word_i,
  input  backend_pkg::retire_t         retire_i,
  input  logic [XLEN-1:0]              retire_data_i,
  output int                           err_count_o,
  output int                           legal_count_o,
  output int                           retire_count_o,
  output logic                         queue_empty_o
);

  localparam int EW = backend_pkg::REG_AW + XLEN;

  logic [XLEN-1:0] model_regs [0:backend_pkg::NUM_REGS-1];
  // Expected retirements in program order, {rd, value}
  logic [EW-1:0]   expect_q [$];
  logic            ack_q;

  //////////////////////////////////////////////////
  // Reference model of one accepted word
  //////////////////////////////////////////////////

  task automatic apply_word(input logic [31:0] w);
    logic [6:0]      opc;
    logic [6:0]      f7;
    logic [2:0]      f3;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] res;
    logic [XLEN-1:0] exp_val;
    logic            legal;
    opc = w[6:0];
    rd = w[11:7];
    f3 = w[14:12];
    rs1 = w[19:15];
    rs2 = w[24:20];
    f7 = w[31:25];
    a = model_regs[rs1];
    b = model_regs[rs2];
    imm = {{(XLEN - 12){w[31]}}, w[31:20]};
    res = '0;
    legal = 1'b1;
    if (opc == backend_pkg::OPC_REG) begin
      case ({f7, f3})
        10'b0000000_000: res = a + b;
        10'b0100000_000: res = a - b;
        10'b0000000_111: res = a & b;
        10'b0000000_110: res = a | b;
        10'b0000000_100: res = a ^ b;
        10'b0000001_000: res = a * b;
        default:         legal = 1'b0;
      endcase
    end else if (opc == backend_pkg::OPC_IMM) begin
      case (f3)
        3'b000:  res = a + imm;
        3'b111:  res = a & imm;
        3'b110:  res = a | imm;
        3'b100:  res = a ^ imm;
        default: legal = 1'b0;
      endcase
    end else begin
      legal = 1'b0;
    end
    if (legal) begin
      exp_val = (rd == 5'd0) ? '0 : res;
      if (rd != 5'd0) begin
        model_regs[rd] = res;
      end
      expect_q.push_back({rd, exp_val});
      legal_count_o++;
    end
  endtask

  //////////////////////////////////////////////////
  // Watch intake and retire ports
  //////////////////////////////////////////////////

  always @(posedge clk_i or negedge rst_ni) begin
    logic [EW-1:0] exp;
    if (!rst_ni) begin
      for (int i = 0; i < backend_pkg::NUM_REGS; i++) begin
        model_regs[i] = '0;
      end
      expect_q.delete();
      ack_q = 1'b0;
      err_count_o = 0;
      legal_count_o = 0;
      retire_count_o = 0;
    end else begin
      // Word is still held by the source on the first cycle of ack
      if (instr_ack_i && !ack_q) begin
        apply_word(instr_word_i);
      end
      ack_q = instr_ack_i;

      if (retire_i.valid) begin
        retire_count_o++;
        if (expect_q.size() == 0) begin
          $display("Unexpected retirement of x%0d at %0t with nothing outstanding",
                   retire_i.rd, $time);
          err_count_o++;
        end else begin
          exp = expect_q.pop_front();
          if (retire_i.rd !== exp[EW-1:XLEN] || retire_data_i !== exp[XLEN-1:0]) begin
            $display("ERROR %0t: retired x%0d = %h, expected x%0d = %h", $time,
                     retire_i.rd, retire_data_i, exp[EW-1:XLEN], exp[XLEN-1:0]);
            err_count_o++;
          end
        end
      end
    end
    queue_empty_o = (expect_q.size() == 0);
  end

endmodule

`default_nettype wire

// ==== test/tb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_top;

  localparam int          XLEN          = 32;
  localparam logic [31:0] SEED          = 32'd95371;
  localparam int          NUM_WORDS     = 300;
  localparam int          ACK_TIMEOUT   = 500;
  localparam int          DRAIN_TIMEOUT = 2000;

  logic                         clk;
  logic                         rst_n;
  logic                         instr_req;
  logic [backend_pkg::ILEN-1:0] instr_word;
  logic                         instr_ack;
  backend_pkg::retire_t         retire;
  logic [XLEN-1:0]              retire_data;

  int          chk_errs;
  int          chk_legal;
  int          chk_retired;
  logic        chk_empty;
  logic [31:0] lfsr_q;
  int          local_errs;
  int          tests_run;
  int          tests_failed;
  logic        timed_out;

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  backend_top #(
    .XLEN (XLEN)
  ) dut (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .instr_req_i   (instr_req),
    .instr_word_i  (instr_word),
    .instr_ack_o   (instr_ack),
    .retire_o      (retire),
    .retire_data_o (retire_data)
  );

  tb_checker #(
    .XLEN (XLEN)
  ) u_checker (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .instr_ack_i    (instr_ack),
    .instr_word_i   (instr_word),
    .retire_i       (retire),
    .retire_data_i  (retire_data),
    .err_count_o    (chk_errs),
    .legal_count_o  (chk_legal),
    .retire_count_o (chk_retired),
    .queue_empty_o  (chk_empty)
  );

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  // Roughly 5% illegal, 10% MUL, the rest ALU in either form
  task automatic make_word(output logic [31:0] w);
    logic [31:0] sel;
    logic [31:0] rd;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic [31:0] pick;
    logic [31:0] imm;
    logic [6:0]  f7;
    logic [2:0]  f3;
    int          bucket;
    take_bits(10, sel);
    take_bits(3, rd);
    take_bits(3, rs1);
    take_bits(3, rs2);
    bucket = int'(sel % 100);
    f7 = 7'b0000000;
    f3 = 3'b000;
    if (bucket < 5) begin
      take_bits(32, w);
      if (w[6:0] == backend_pkg::OPC_REG || w[6:0] == backend_pkg::OPC_IMM) begin
        w[6] = ~w[6];
      end
    end else if (bucket < 15) begin
      w = {7'b0000001, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], backend_pkg::OPC_REG};
    end else begin
      take_bits(1, pick);
      if (pick[0]) begin
        take_bits(3, pick);
        case (pick % 5)
          1: f7 = 7'b0100000;
          2: f3 = 3'b111;
          3: f3 = 3'b110;
          4: f3 = 3'b100;
          default: ;
        endcase
        w = {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], backend_pkg::OPC_REG};
      end else begin
        take_bits(2, pick);
        case (pick[1:0])
          2'd1: f3 = 3'b111;
          2'd2: f3 = 3'b110;
          2'd3: f3 = 3'b100;
          default: ;
        endcase
        take_bits(12, imm);
        w = {imm[11:0], rs1[4:0], f3, rd[4:0], backend_pkg::OPC_IMM};
      end
    end
  endtask

  task automatic wait_ack(input logic level, output logic ok);
    int n;
    n = 0;
    while (instr_ack !== level && n < ACK_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    ok = (instr_ack === level);
  endtask

  // Four-phase transfer of one word, all edges on the falling clock
  task automatic send_word(input logic [31:0] w, output logic ok);
    @(negedge clk);
    instr_word = w;
    instr_req = 1'b1;
    wait_ack(1'b1, ok);
    if (!ok) begin
      $display("Timeout: no ack for word %h within %0d cycles", w, ACK_TIMEOUT);
    end else begin
      instr_req = 1'b0;
      wait_ack(1'b0, ok);
      if (!ok) begin
        $display("Timeout: ack still high %0d cycles after req fell", ACK_TIMEOUT);
      end
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    int errs;
    errs = local_errs + chk_errs - errs_before;
    tests_run++;
    if (errs == 0) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: FAILED with %0d errors", name, errs);
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    logic        ok;
    logic [31:0] w;
    int          base;
    int          n;
    instr_req = 1'b0;
    instr_word = '0;
    rst_n = 1'b0;
    lfsr_q = SEED;
    local_errs = 0;
    tests_run = 0;
    tests_failed = 0;
    timed_out = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    base = local_errs + chk_errs;
    if (instr_ack !== 1'b0 || retire.valid !== 1'b0) begin
      $display("ERROR %0t: ack or retire valid not low after reset", $time);
      local_errs++;
    end
    report_test("reset_state", base);

    base = local_errs + chk_errs;
    for (int i = 0; i < NUM_WORDS && !timed_out; i++) begin
      make_word(w);
      send_word(w, ok);
      if (!ok) begin
        timed_out = 1'b1;
        local_errs++;
      end
    end
    report_test("random_stream", base);

    base = local_errs + chk_errs;
    if (!timed_out) begin
      n = 0;
      while (!chk_empty && n < DRAIN_TIMEOUT) begin
        @(negedge clk);
        n++;
      end
      if (!chk_empty) begin
        $display("Timeout: instructions still outstanding after %0d cycles", DRAIN_TIMEOUT);
        timed_out = 1'b1;
        local_errs++;
      end
    end
    report_test("drain", base);

    base = local_errs + chk_errs;
    if (chk_retired != chk_legal) begin
      $display("Retired %0d instructions but %0d legal words were accepted",
               chk_retired, chk_legal);
      local_errs++;
    end
    report_test("retire_count", base);

    base = local_errs + chk_errs;
    if (dut.u_chk.fail_count != 0) begin
      $display("Intake or retire protocol assertions failed %0d times",
               dut.u_chk.fail_count);
      local_errs++;
    end
    report_test("protocol", base);

    $display("%0d tests, %0d failed, %0d errors, %0d legal words, %0d retired",
             tests_run, tests_failed, local_errs + chk_errs, chk_legal, chk_retired);
    if (tests_failed == 0 && !timed_out) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
logic/backend_pkg.sv
logic/instr_intake.sv
logic/reg_file.sv
logic/operand_bypass.sv
logic/seq_multiplier.sv
logic/exec_pipeline.sv
logic/backend_top.sv
test/backend_chk.sv
test/tb_checker.sv
test/tb_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f tb.f \
  && ./obj_dir/Vtb_top | tee /dev/stderr | grep "Regression passed" > /dev/null \
  && echo "simulation PASS" \
  || { echo "simulation FAIL"; exit 1; }
